/* design/ppu_defines.svh */
`ifndef PPU_DEFINES_SVH
`define PPU_DEFINES_SVH

// Composed row is eight pixels of 8-bit colour codes
`define PPU_ROW_W 64

// Palette size
// Lower 16 entries hold background groups and upper 16 hold sprite groups
`define PPU_PAL_ENTRIES 32

// Rows the downstream buffer can take before it returns a credit
`define PPU_OUT_CREDITS 4

`endif

/* design/ppu_pkg.sv */
package ppu_pkg;

	// Configuration port opcode
	typedef enum logic {
		// Load the control register from cfg_data
		CFG_CTRL2   = 1'b0,
		// Load one palette entry at cfg_addr
		CFG_PALETTE = 1'b1
	} cfg_op_t;

	// Row loader slot state
	typedef enum logic {
		// Nothing held and ready for a new row
		LD_EMPTY = 1'b0,
		// Holding a row for the compositor
		LD_FULL  = 1'b1
	} ld_state_t;

endpackage

/* design/ppu_regs.sv */
`timescale 1ns/1ns
`include "ppu_defines.svh"

module ppu_regs (
	input  logic             clk,
	input  logic             arst_n,
	// Configuration write port
	input  logic             cfg_valid,
	input  ppu_pkg::cfg_op_t cfg_op,
	input  logic [4:0]       cfg_addr,
	input  logic [7:0]       cfg_data,
	// Group selects of the row being composed
	input  logic [1:0]       bg_pal_sel,
	input  logic [1:0]       s0_pal_sel,
	input  logic [1:0]       s1_pal_sel,
	// Register contents for the compositor
	output logic [7:0]       ctrl2,
	output logic [31:0]      bg_colors,
	output logic [31:0]      s0_colors,
	output logic [31:0]      s1_colors
);
	import ppu_pkg::*;

	// Palette entries, four per colour group
	logic [7:0] palette [0:`PPU_PAL_ENTRIES-1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl2 <= 8'h00;
			for (int i = 0; i < `PPU_PAL_ENTRIES; i++) begin
				palette[i] <= 8'h00;
			end
		end else if (cfg_valid) begin
			if (cfg_op == CFG_CTRL2) begin
				ctrl2 <= cfg_data;
			end else begin
				palette[cfg_addr] <= cfg_data;
			end
		end
	end

	// Pack four consecutive entries into one group word
	// Colour n lands at bits 8n upward
	function automatic logic [31:0] color_group(input logic [4:0] base);
		logic [31:0] grp;
		for (int n = 0; n < 4; n++) begin
			grp[8*n +: 8] = palette[base + 5'(n)];
		end
		return grp;
	endfunction

	always_comb begin
		// Background groups live in the lower half
		bg_colors = color_group({1'b0, bg_pal_sel, 2'b00});
		// Sprite groups live in the upper half
		s0_colors = color_group({1'b1, s0_pal_sel, 2'b00});
		s1_colors = color_group({1'b1, s1_pal_sel, 2'b00});
	end

endmodule

/* design/row_loader.sv */
`timescale 1ns/1ns

module row_loader (
	input  logic       clk,
	input  logic       arst_n,
	// Row input handshake
	input  logic       row_valid,
	output logic       row_ready,
	// Incoming row fields
	input  logic [7:0] bg_low,
	input  logic [7:0] bg_high,
	input  logic [1:0] bg_pal,
	input  logic [7:0] s0_low,
	input  logic [7:0] s0_high,
	input  logic [7:0] s0_attr,
	input  logic [7:0] s1_low,
	input  logic [7:0] s1_high,
	input  logic [7:0] s1_attr,
	// Emitter takes the held row this cycle
	input  logic       load_take,
	// Held row toward compositor and registers
	output logic       held_valid,
	output logic [7:0] h_bg_low,
	output logic [7:0] h_bg_high,
	output logic [1:0] h_bg_pal,
	output logic [7:0] h_s0_low,
	output logic [7:0] h_s0_high,
	output logic [7:0] h_s0_attr,
	output logic [7:0] h_s1_low,
	output logic [7:0] h_s1_high,
	output logic [7:0] h_s1_attr
);
	import ppu_pkg::*;

	ld_state_t state;
	logic      live;
	logic      row_fire;

	// Goes high on the first edge after reset release
	// Keeps ready low while reset is applied
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			live <= 1'b0;
		end else begin
			live <= 1'b1;
		end
	end

	// Slot can accept when empty or when being drained this cycle
	assign row_ready  = live && ((state == LD_EMPTY) || load_take);
	assign row_fire   = row_valid && row_ready;
	assign held_valid = (state == LD_FULL);

	// Slot occupancy
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= LD_EMPTY;
		end else if (row_fire) begin
			// Refill covers the drain-and-load case too
			state <= LD_FULL;
		end else if (load_take) begin
			state <= LD_EMPTY;
		end
	end

	// Row payload, only written on a transfer
	always_ff @(posedge clk) begin
		if (row_fire) begin
			h_bg_low  <= bg_low;
			h_bg_high <= bg_high;
			h_bg_pal  <= bg_pal;
			h_s0_low  <= s0_low;
			h_s0_high <= s0_high;
			h_s0_attr <= s0_attr;
			h_s1_low  <= s1_low;
			h_s1_high <= s1_high;
			h_s1_attr <= s1_attr;
		end
	end

endmodule

/* design/pixel_mux.sv */
`timescale 1ns/1ns
`include "ppu_defines.svh"

module pixel_mux (
	// Bit 3 enables background and bit 4 enables sprites
	input  logic [7:0]            ctrl2,
	// Background pattern planes and group colours
	input  logic [7:0]            bg_low,
	input  logic [7:0]            bg_high,
	input  logic [31:0]           bg_colors,
	// Sprite 0
	input  logic [7:0]            s0_low,
	input  logic [7:0]            s0_high,
	input  logic [7:0]            s0_attr,
	input  logic [31:0]           s0_colors,
	// Sprite 1
	input  logic [7:0]            s1_low,
	input  logic [7:0]            s1_high,
	input  logic [7:0]            s1_attr,
	input  logic [31:0]           s1_colors,
	// Composed row and sprite-hit flags
	output logic [`PPU_ROW_W-1:0] pixels,
	output logic                  hit0,
	output logic                  hit1
);

	logic bg_en;
	logic spr_en;

	assign bg_en  = ctrl2[3];
	assign spr_en = ctrl2[4];

	// 2-bit colour index of pixel i from its two planes
	function automatic logic [1:0] pix_index(input logic [7:0] low, input logic [7:0] high,
		input int i);
		return {high[i], low[i]};
	endfunction

	// Colour n of a group word
	function automatic logic [7:0] pick(input logic [31:0] colors, input logic [1:0] idx);
		return colors[8*idx +: 8];
	endfunction

	// Opaque sprite pixel drawn when in front or over empty background
	function automatic logic sprite_drawn(input logic en, input logic [1:0] s_idx,
		input logic [7:0] attr, input logic [1:0] b_idx);
		return en && (s_idx != 2'b00) && (!attr[5] || (b_idx == 2'b00));
	endfunction

	// Any opaque sprite pixel over an opaque background pixel
	function automatic logic overlap(input logic [7:0] low, input logic [7:0] high);
		return |((bg_low | bg_high) & (low | high));
	endfunction

	// Hits ignore the enables
	assign hit0 = overlap(s0_low, s0_high);
	assign hit1 = overlap(s1_low, s1_high);

	always_comb begin
		logic [1:0] b_idx;
		logic [1:0] s0_idx;
		logic [1:0] s1_idx;
		for (int i = 0; i < 8; i++) begin
			b_idx  = pix_index(bg_low, bg_high, i);
			s0_idx = pix_index(s0_low, s0_high, i);
			s1_idx = pix_index(s1_low, s1_high, i);
			// Sprite 0 has priority over sprite 1
			if (sprite_drawn(spr_en, s0_idx, s0_attr, b_idx)) begin
				pixels[8*i +: 8] = pick(s0_colors, s0_idx);
			end else if (sprite_drawn(spr_en, s1_idx, s1_attr, b_idx)) begin
				pixels[8*i +: 8] = pick(s1_colors, s1_idx);
			end else if (bg_en && (b_idx != 2'b00)) begin
				pixels[8*i +: 8] = pick(bg_colors, b_idx);
			end else begin
				// Transparent everywhere
				pixels[8*i +: 8] = 8'h00;
			end
		end
	end

endmodule

/* design/row_emitter.sv */
`timescale 1ns/1ns
`include "ppu_defines.svh"

module row_emitter (
	input  logic                  clk,
	input  logic                  arst_n,
	// Composed row from the loader and compositor
	input  logic                  held_valid,
	input  logic [`PPU_ROW_W-1:0] pixels,
	input  logic                  hit0,
	input  logic                  hit1,
	// One pulse returns one downstream credit
	input  logic                  out_credit,
	// Row moves from loader into the output register
	output logic                  load_take,
	// Row output toward the downstream buffer
	output logic                  out_valid,
	output logic [`PPU_ROW_W-1:0] out_pixels,
	output logic                  out_hit0,
	output logic                  out_hit1
);

	localparam int               CNT_W   = $clog2(`PPU_OUT_CREDITS + 1);
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`PPU_OUT_CREDITS);

	logic             full;
	logic [CNT_W-1:0] credits;

	// Issue whenever a row is held and a credit is available
	assign out_valid = full && (credits != '0);

	// Take a new row when free or when the current one leaves now
	assign load_take = held_valid && (!full || out_valid);

	// Output register occupancy
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			full <= 1'b0;
		end else if (load_take) begin
			full <= 1'b1;
		end else if (out_valid) begin
			full <= 1'b0;
		end
	end

	// Row payload and flags
	always_ff @(posedge clk) begin
		if (load_take) begin
			out_pixels <= pixels;
			out_hit0   <= hit0;
			out_hit1   <= hit1;
		end
	end

	// Credit counter
	// Return and spend together cancel out
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credits <= CNT_MAX;
		end else if (out_credit && !out_valid) begin
			// Saturate at the buffer depth
			if (credits != CNT_MAX) begin
				credits <= credits + 1'b1;
			end
		end else if (out_valid && !out_credit) begin
			credits <= credits - 1'b1;
		end
	end

endmodule

/* design/ppu_row_top.sv */
`timescale 1ns/1ns
`include "ppu_defines.svh"

module ppu_row_top (
	input  logic                  clk,
	input  logic                  arst_n,
	// Configuration port
	input  logic                  cfg_valid,
	input  ppu_pkg::cfg_op_t      cfg_op,
	input  logic [4:0]            cfg_addr,
	input  logic [7:0]            cfg_data,
	// Row input
	input  logic                  row_valid,
	output logic                  row_ready,
	input  logic [7:0]            bg_low,
	input  logic [7:0]            bg_high,
	input  logic [1:0]            bg_pal,
	input  logic [7:0]            s0_low,
	input  logic [7:0]            s0_high,
	input  logic [7:0]            s0_attr,
	input  logic [7:0]            s1_low,
	input  logic [7:0]            s1_high,
	input  logic [7:0]            s1_attr,
	// Row output with credit return
	output logic                  out_valid,
	output logic [`PPU_ROW_W-1:0] out_pixels,
	output logic                  out_hit0,
	output logic                  out_hit1,
	input  logic                  out_credit
);

	// Held row
	logic                  held_valid;
	logic                  load_take;
	logic [7:0]            h_bg_low;
	logic [7:0]            h_bg_high;
	logic [1:0]            h_bg_pal;
	logic [7:0]            h_s0_low;
	logic [7:0]            h_s0_high;
	logic [7:0]            h_s0_attr;
	logic [7:0]            h_s1_low;
	logic [7:0]            h_s1_high;
	logic [7:0]            h_s1_attr;

	// Register file outputs
	logic [7:0]            ctrl2;
	logic [31:0]           bg_colors;
	logic [31:0]           s0_colors;
	logic [31:0]           s1_colors;

	// Compositor outputs
	logic [`PPU_ROW_W-1:0] pixels;
	logic                  hit0;
	logic                  hit1;

	// Sprite groups come from attribute bits 1:0
	ppu_regs u_regs (
		.clk        (clk),
		.arst_n     (arst_n),
		.cfg_valid  (cfg_valid),
		.cfg_op     (cfg_op),
		.cfg_addr   (cfg_addr),
		.cfg_data   (cfg_data),
		.bg_pal_sel (h_bg_pal),
		.s0_pal_sel (h_s0_attr[1:0]),
		.s1_pal_sel (h_s1_attr[1:0]),
		.ctrl2      (ctrl2),
		.bg_colors  (bg_colors),
		.s0_colors  (s0_colors),
		.s1_colors  (s1_colors)
	);

	row_loader u_loader (
		.clk        (clk),
		.arst_n     (arst_n),
		.row_valid  (row_valid),
		.row_ready  (row_ready),
		.bg_low     (bg_low),
		.bg_high    (bg_high),
		.bg_pal     (bg_pal),
		.s0_low     (s0_low),
		.s0_high    (s0_high),
		.s0_attr    (s0_attr),
		.s1_low     (s1_low),
		.s1_high    (s1_high),
		.s1_attr    (s1_attr),
		.load_take  (load_take),
		.held_valid (held_valid),
		.h_bg_low   (h_bg_low),
		.h_bg_high  (h_bg_high),
		.h_bg_pal   (h_bg_pal),
		.h_s0_low   (h_s0_low),
		.h_s0_high  (h_s0_high),
		.h_s0_attr  (h_s0_attr),
		.h_s1_low   (h_s1_low),
		.h_s1_high  (h_s1_high),
		.h_s1_attr  (h_s1_attr)
	);

	// Combinational between loader and emitter
	pixel_mux u_mux (
		.ctrl2     (ctrl2),
		.bg_low    (h_bg_low),
		.bg_high   (h_bg_high),
		.bg_colors (bg_colors),
		.s0_low    (h_s0_low),
		.s0_high   (h_s0_high),
		.s0_attr   (h_s0_attr),
		.s0_colors (s0_colors),
		.s1_low    (h_s1_low),
		.s1_high   (h_s1_high),
		.s1_attr   (h_s1_attr),
		.s1_colors (s1_colors),
		.pixels    (pixels),
		.hit0      (hit0),
		.hit1      (hit1)
	);

	row_emitter u_emitter (
		.clk        (clk),
		.arst_n     (arst_n),
		.held_valid (held_valid),
		.pixels     (pixels),
		.hit0       (hit0),
		.hit1       (hit1),
		.out_credit (out_credit),
		.load_take  (load_take),
		.out_valid  (out_valid),
		.out_pixels (out_pixels),
		.out_hit0   (out_hit0),
		.out_hit1   (out_hit1)
	);

endmodule

/* tests/ppu_row_model.svh */
`ifndef PPU_ROW_MODEL_SVH
`define PPU_ROW_MODEL_SVH

// Palette image holds entry k at bits 8k upward
function automatic logic [7:0] palette_entry(input logic [`PPU_PAL_ENTRIES*8-1:0] pal,
	input int k);
	return pal[8*k +: 8];
endfunction

// Opaque sprite pixel shows unless it sits behind an opaque background pixel
function automatic bit sprite_visible(input bit spr_on, input int s_idx, input bit behind,
	input int b_idx);
	if (!spr_on || s_idx == 0) begin
		return 1'b0;
	end
	return !behind || b_idx == 0;
endfunction

// Expected {hit1, hit0, pixels} of one row
function automatic logic [`PPU_ROW_W+1:0] compose_row(input logic [7:0] ctrl,
	input logic [`PPU_PAL_ENTRIES*8-1:0] pal,
	input logic [7:0] bl, input logic [7:0] bh, input logic [1:0] bp,
	input logic [7:0] s0l, input logic [7:0] s0h, input logic [7:0] s0a,
	input logic [7:0] s1l, input logic [7:0] s1h, input logic [7:0] s1a);
	logic [`PPU_ROW_W-1:0] row;
	logic                  h0;
	logic                  h1;
	int                    b_idx;
	int                    i0;
	int                    i1;
	row = '0;
	h0  = 1'b0;
	h1  = 1'b0;
	for (int p = 0; p < 8; p++) begin
		// High plane is the upper index bit
		b_idx = 2 * int'(bh[p]) + int'(bl[p]);
		i0    = 2 * int'(s0h[p]) + int'(s0l[p]);
		i1    = 2 * int'(s1h[p]) + int'(s1l[p]);
		// Overlap flags ignore both enables
		if (i0 != 0 && b_idx != 0) h0 = 1'b1;
		if (i1 != 0 && b_idx != 0) h1 = 1'b1;
		// Sprite groups start at entry 16
		if (sprite_visible(ctrl[4], i0, s0a[5], b_idx)) begin
			row[8*p +: 8] = palette_entry(pal, 16 + 4 * int'(s0a[1:0]) + i0);
		end else if (sprite_visible(ctrl[4], i1, s1a[5], b_idx)) begin
			row[8*p +: 8] = palette_entry(pal, 16 + 4 * int'(s1a[1:0]) + i1);
		end else if (ctrl[3] && b_idx != 0) begin
			row[8*p +: 8] = palette_entry(pal, 4 * int'(bp) + b_idx);
		end
	end
	return {h1, h0, row};
endfunction

`endif

/* tests/ppu_row_tb.sv */
`timescale 1ns/1ns
`include "ppu_defines.svh"

module ppu_row_tb;
	import ppu_pkg::*;

	`include "ppu_row_model.svh"

	// Row counts per test
	localparam int N_DIRECTED   = 7;
	localparam int N_BG         = 8;
	localparam int N_MIX        = 10;
	localparam int N_OFF        = 8;
	localparam int N_FLOW       = 40;
	localparam int ROWS_TOTAL   = N_DIRECTED + N_BG + N_MIX + N_OFF + N_FLOW;
	// Reset, palette load and control writes
	localparam int SETUP_CYCLES = 120;

	logic                  clk;
	logic                  arst_n;
	logic                  cfg_valid;
	cfg_op_t               cfg_op;
	logic [4:0]            cfg_addr;
	logic [7:0]            cfg_data;
	logic                  row_valid;
	logic                  row_ready;
	logic [7:0]            bg_low;
	logic [7:0]            bg_high;
	logic [1:0]            bg_pal;
	logic [7:0]            s0_low;
	logic [7:0]            s0_high;
	logic [7:0]            s0_attr;
	logic [7:0]            s1_low;
	logic [7:0]            s1_high;
	logic [7:0]            s1_attr;
	logic                  out_valid;
	logic [`PPU_ROW_W-1:0] out_pixels;
	logic                  out_hit0;
	logic                  out_hit1;
	logic                  out_credit;

	// Testbench copies of the programmed registers
	logic [`PPU_PAL_ENTRIES*8-1:0] pal_img;
	logic [7:0]                    ctrl_img;
	// Scoreboard, expected word and acceptance cycle per row
	logic [`PPU_ROW_W+1:0]         exp_q[$];
	int                            acc_q[$];
	int                            tb_credits = `PPU_OUT_CREDITS;
	int                            owed = 0;
	int                            cyc = 0;
	int                            rst_cycles = 0;
	int                            errors = 0;
	int                            rows_seen = 0;
	bit                            lone_check = 1'b0;
	bit                            stingy = 1'b0;
	string                         test_name = "reset";

	ppu_row_top UUT (
		.clk        (clk),
		.arst_n     (arst_n),
		.cfg_valid  (cfg_valid),
		.cfg_op     (cfg_op),
		.cfg_addr   (cfg_addr),
		.cfg_data   (cfg_data),
		.row_valid  (row_valid),
		.row_ready  (row_ready),
		.bg_low     (bg_low),
		.bg_high    (bg_high),
		.bg_pal     (bg_pal),
		.s0_low     (s0_low),
		.s0_high    (s0_high),
		.s0_attr    (s0_attr),
		.s1_low     (s1_low),
		.s1_high    (s1_high),
		.s1_attr    (s1_attr),
		.out_valid  (out_valid),
		.out_pixels (out_pixels),
		.out_hit0   (out_hit0),
		.out_hit1   (out_hit1),
		.out_credit (out_credit)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Scoreboard, credit tracking and all checks
	always @(posedge clk or negedge arst_n) begin
		logic [`PPU_ROW_W+1:0] exp_word;
		int                    acc_cyc;
		if (!arst_n) begin
			tb_credits <= `PPU_OUT_CREDITS;
			owed       <= 0;
			cyc        <= 0;
			rst_cycles <= rst_cycles + 1;
			// First edges only start the reset
			if (rst_cycles > 1) begin
				assert (!row_ready && !out_valid) else begin
					errors++;
					$display("Row handshake active while reset is applied");
				end
			end
		end else begin
			cyc        <= cyc + 1;
			tb_credits <= tb_credits - int'(out_valid) + int'(out_credit);
			owed       <= owed + int'(out_valid) - int'(out_credit);
			// Emitter counter stays within the buffer depth
			assert (int'(UUT.u_emitter.credits) <= `PPU_OUT_CREDITS) else begin
				errors++;
				$display("Credit count %0d above buffer depth in %s",
					UUT.u_emitter.credits, test_name);
			end
			if (out_valid) begin
				assert (tb_credits != 0) else begin
					errors++;
					$display("Row issued with no credit held in %s", test_name);
				end
				if (exp_q.size() == 0) begin
					errors++;
					$display("Row issued in %s with none outstanding", test_name);
				end else begin
					exp_word = exp_q.pop_front();
					acc_cyc  = acc_q.pop_front();
					rows_seen++;
					assert (out_pixels == exp_word[`PPU_ROW_W-1:0]) else begin
						errors++;
						$display("FAIL %s pixels expected %h actual %h", test_name,
							exp_word[`PPU_ROW_W-1:0], out_pixels);
					end
					assert ({out_hit1, out_hit0} == exp_word[`PPU_ROW_W+1:`PPU_ROW_W]) else begin
						errors++;
						$display("FAIL %s hits expected %b actual %b", test_name,
							exp_word[`PPU_ROW_W+1:`PPU_ROW_W], {out_hit1, out_hit0});
					end
					// Idle emitter with credits gives the fixed two-edge latency
					if (lone_check) begin
						assert (cyc - acc_cyc == 2) else begin
							errors++;
							$display("FAIL %s latency expected 2 actual %0d", test_name,
								cyc - acc_cyc);
						end
					end
				end
			end
			if (row_valid && row_ready) begin
				exp_q.push_back(compose_row(ctrl_img, pal_img, bg_low, bg_high, bg_pal,
					s0_low, s0_high, s0_attr, s1_low, s1_high, s1_attr));
				acc_q.push_back(cyc);
			end
		end
	end

	// Downstream buffer returning credits after random delays
	initial begin
		int hold;
		hold       = 0;
		out_credit = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			out_credit = 1'b0;
			if (hold > 0) begin
				hold--;
			end else if (owed > 0 && $urandom_range(2) == 0) begin
				out_credit = 1'b1;
				// Sometimes sit on the remaining credits for a while
				if ($urandom_range(stingy ? 6 : 20) == 0) begin
					hold = stingy ? int'($urandom_range(60, 25)) : int'($urandom_range(10, 3));
				end
			end
		end
	end

	initial begin
		repeat (ROWS_TOTAL * 40 + SETUP_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d of %0d rows", rows_seen, ROWS_TOTAL);
		$display("test failed");
		$finish;
	end

	task automatic write_cfg(input cfg_op_t op, input logic [4:0] addr, input logic [7:0] data);
		cfg_valid = 1'b1;
		cfg_op    = op;
		cfg_addr  = addr;
		cfg_data  = data;
		@(posedge clk);
		#1;
		cfg_valid = 1'b0;
	endtask

	task automatic set_ctrl(input logic [7:0] value);
		write_cfg(CFG_CTRL2, 5'd0, value);
		ctrl_img = value;
	endtask

	// Distinct nonzero colour in every entry
	task automatic program_palette();
		for (int k = 0; k < `PPU_PAL_ENTRIES; k++) begin
			write_cfg(CFG_PALETTE, 5'(k), 8'(k * 7 + 3));
			pal_img[8*k +: 8] = 8'(k * 7 + 3);
		end
	endtask

	// Holds the row on the bus until the edge that accepts it
	task automatic send_row(input logic [7:0] b_lo, input logic [7:0] b_hi,
		input logic [1:0] b_pal, input logic [7:0] a_lo, input logic [7:0] a_hi,
		input logic [7:0] a_attr, input logic [7:0] c_lo, input logic [7:0] c_hi,
		input logic [7:0] c_attr);
		bg_low    = b_lo;
		bg_high   = b_hi;
		bg_pal    = b_pal;
		s0_low    = a_lo;
		s0_high   = a_hi;
		s0_attr   = a_attr;
		s1_low    = c_lo;
		s1_high   = c_hi;
		s1_attr   = c_attr;
		row_valid = 1'b1;
		do begin
			@(posedge clk);
		end while (!row_ready);
		#1;
	endtask

	task automatic send_random_rows(input int count);
		for (int n = 0; n < count; n++) begin
			send_row(8'($urandom), 8'($urandom), 2'($urandom), 8'($urandom), 8'($urandom),
				8'($urandom), 8'($urandom), 8'($urandom), 8'($urandom));
		end
	endtask

	// Wait until every accepted row has been checked
	task automatic drain_rows();
		row_valid = 1'b0;
		do begin
			@(posedge clk);
			#1;
		end while (exp_q.size() != 0);
	endtask

	initial begin
		void'($urandom(32'h14b3_3cf3));
		arst_n    = 1'b0;
		cfg_valid = 1'b0;
		cfg_op    = CFG_CTRL2;
		cfg_addr  = 5'd0;
		cfg_data  = 8'h00;
		row_valid = 1'b0;
		bg_low    = 8'h00;
		bg_high   = 8'h00;
		bg_pal    = 2'd0;
		s0_low    = 8'h00;
		s0_high   = 8'h00;
		s0_attr   = 8'h00;
		s1_low    = 8'h00;
		s1_high   = 8'h00;
		s1_attr   = 8'h00;
		pal_img   = '0;
		ctrl_img  = 8'h00;
		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(posedge clk);
		#1;
		program_palette();

		// Background only, sprite data present but disabled
		test_name = "bg_only";
		set_ctrl(8'h08);
		send_row(8'hAA, 8'hCC, 2'd1, 8'hFF, 8'hFF, 8'h00, 8'h0F, 8'hF0, 8'h03);
		send_random_rows(N_BG);
		drain_rows();

		// Behind and front sprites, sprite 0 over sprite 1
		test_name = "sprite_priority";
		set_ctrl(8'h18);
		send_row(8'h0F, 8'h00, 2'd2, 8'hFF, 8'h00, 8'h21, 8'h00, 8'h00, 8'h00);
		send_row(8'h0F, 8'h00, 2'd2, 8'hFF, 8'hFF, 8'h02, 8'h00, 8'h00, 8'h00);
		send_row(8'hF0, 8'h33, 2'd3, 8'h00, 8'h00, 8'h00, 8'hFF, 8'h0F, 8'h22);
		send_row(8'h00, 8'h00, 2'd0, 8'h3C, 8'h00, 8'h00, 8'hFF, 8'hFF, 8'h03);
		send_row(8'h81, 8'h18, 2'd1, 8'hF0, 8'hAA, 8'h01, 8'h0F, 8'h55, 8'h02);
		send_random_rows(N_MIX);
		drain_rows();

		// Both enables off, hits still reported
		test_name = "enables_off";
		set_ctrl(8'h00);
		send_random_rows(N_OFF);
		drain_rows();
		while (tb_credits != `PPU_OUT_CREDITS) begin
			@(posedge clk);
			#1;
		end
		lone_check = 1'b1;
		send_row(8'hFF, 8'h0F, 2'd3, 8'h0F, 8'h00, 8'h00, 8'hF0, 8'h00, 8'h00);
		drain_rows();
		lone_check = 1'b0;

		// Back-to-back rows against a slow consumer
		test_name = "credit_flow";
		set_ctrl(8'h18);
		stingy = 1'b1;
		send_random_rows(N_FLOW);
		drain_rows();

		$display("Checked %0d of %0d rows with %0d errors", rows_seen, ROWS_TOTAL, errors);
		if (errors == 0 && rows_seen == ROWS_TOTAL) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* all.f */
+incdir+design
+incdir+tests
design/ppu_pkg.sv
design/ppu_regs.sv
design/row_loader.sv
design/pixel_mux.sv
design/row_emitter.sv
design/ppu_row_top.sv
tests/ppu_row_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run, pass decided by the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module ppu_row_tb -f all.f -o ppu_row_sim &&
	./obj_dir/ppu_row_sim | tee /dev/stderr | grep -x "test passed" > /dev/null ||
	{ echo "simulation did not pass"; exit 1; }
